// File: Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_pkg.sv
      - verilog/core_pkg.sv
      - verilog/channel_slice.sv
      - verilog/mem_arbiter.sv
      - verilog/addr_router.sv
      - verilog/sram_slave.sv
      - verilog/mem_subsys_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/mem_subsys_tb.sv

// File: all.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/core_pkg.sv
verilog/channel_slice.sv
verilog/mem_arbiter.sv
verilog/addr_router.sv
verilog/sram_slave.sv
verilog/mem_subsys_top.sv
verif/mem_subsys_tb.sv

// File: verif/mem_subsys_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_tb;

	localparam int TIMEOUT = 100; // Cycles allowed for any single handshake.
	localparam axi_pkg::addr_t SRAM_BASE_TB = 32'h8000_0000;
	localparam int SRAM_WORDS_TB = 1024;
	localparam axi_pkg::addr_t SRAM_END_TB = SRAM_BASE_TB + SRAM_WORDS_TB * 4;
	localparam axi_pkg::resp_t OKAY = axi_pkg::RESP_OKAY;
	localparam axi_pkg::resp_t DECERR = axi_pkg::RESP_DECERR;

	typedef enum logic {PORT_IFU, PORT_LSU} port_e;
	typedef enum logic [1:0] {RD, WR, DUAL_RD, WR_DURING_RD} kind_e;

	// addr2 is the lsu read of a dual read, or the ifu read that runs under an lsu write.
	typedef struct packed {
		port_e          port;
		kind_e          kind;
		axi_pkg::addr_t addr;
		axi_pkg::addr_t addr2;
		axi_pkg::data_t wdata;
		axi_pkg::strb_t strb;
		axi_pkg::resp_t resp;
		axi_pkg::resp_t resp2;
	} row_t;

	localparam int NUM_ROWS = 18;

	row_t rows [NUM_ROWS] = '{
		'{PORT_LSU, WR, 32'h8000_0000, 32'h0, 32'h1122_3344, 4'hf, OKAY, OKAY},
		'{PORT_LSU, WR, 32'h8000_0004, 32'h0, 32'hdead_beef, 4'hf, OKAY, OKAY},
		'{PORT_LSU, WR, 32'h8000_0ffc, 32'h0, 32'h0bad_f00d, 4'hf, OKAY, OKAY},
		'{PORT_LSU, WR, 32'h8000_0004, 32'h0, 32'ha5a5_5a5a, 4'h5, OKAY, OKAY},
		'{PORT_LSU, RD, 32'h8000_0004, 32'h0, 32'h0, 4'h0, OKAY, OKAY},
		'{PORT_IFU, RD, 32'h8000_0000, 32'h0, 32'h0, 4'h0, OKAY, OKAY},
		'{PORT_LSU, WR, 32'h8000_0010, 32'h0, 32'h7654_3210, 4'hf, OKAY, OKAY},
		'{PORT_LSU, WR, 32'h8000_0010, 32'h0, 32'hffff_ffff, 4'h8, OKAY, OKAY},
		'{PORT_IFU, RD, 32'h8000_0010, 32'h0, 32'h0, 4'h0, OKAY, OKAY},
		'{PORT_IFU, DUAL_RD, 32'h8000_0ffc, 32'h8000_0004, 32'h0, 4'h0, OKAY, OKAY},
		// Unmapped addresses just past and just below the window.
		'{PORT_LSU, RD, 32'h8000_1000, 32'h0, 32'h0, 4'h0, DECERR, OKAY},
		'{PORT_IFU, RD, 32'h7fff_fffc, 32'h0, 32'h0, 4'h0, DECERR, OKAY},
		'{PORT_LSU, WR, 32'h8000_1000, 32'h0, 32'hcafe_babe, 4'hf, DECERR, OKAY},
		'{PORT_LSU, WR, 32'h0000_0000, 32'h0, 32'h0123_4567, 4'hf, DECERR, OKAY},
		'{PORT_LSU, RD, 32'h8000_0000, 32'h0, 32'h0, 4'h0, OKAY, OKAY},
		'{PORT_LSU, WR_DURING_RD, 32'h8000_0020, 32'h8000_0010, 32'h1357_9bdf, 4'hf, OKAY, OKAY},
		'{PORT_IFU, RD, 32'h8000_0020, 32'h0, 32'h0, 4'h0, OKAY, OKAY},
		'{PORT_IFU, DUAL_RD, 32'h8000_0020, 32'h9000_0000, 32'h0, 4'h0, OKAY, DECERR}
	};

	logic         clk = 1'b0;
	logic         rst_n;
	axi_pkg::ar_t ifu_ar, lsu_ar;
	axi_pkg::r_t  ifu_r, lsu_r;
	axi_pkg::aw_t lsu_aw;
	axi_pkg::w_t  lsu_w;
	axi_pkg::b_t  lsu_b;
	logic         ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic         lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic         lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;

	axi_pkg::data_t shadow [SRAM_WORDS_TB]; // Starts unknown, like the SRAM itself.
	int cycle_cnt = 0;

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	mem_subsys_top mem_subsys_top_i (
		.clk, .rst_n,
		.ifu_ar, .ifu_arvalid, .ifu_arready, .ifu_r, .ifu_rvalid, .ifu_rready,
		.lsu_ar, .lsu_arvalid, .lsu_arready, .lsu_r, .lsu_rvalid, .lsu_rready,
		.lsu_aw, .lsu_awvalid, .lsu_awready, .lsu_w, .lsu_wvalid, .lsu_wready,
		.lsu_b, .lsu_bvalid, .lsu_bready
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_r(input string name, input axi_pkg::r_t exp, input axi_pkg::r_t act);
		if (act !== exp)
			fail_run($sformatf("Error: %s expected data %h resp %h, got data %h resp %h",
				name, exp.data, exp.resp, act.data, act.resp));
	endtask

	task automatic check_b(input string name, input axi_pkg::b_t exp, input axi_pkg::b_t act);
		if (act !== exp)
			fail_run($sformatf("Error: %s expected resp %h, got resp %h", name, exp.resp, act.resp));
	endtask

	task automatic check_idle(input string when);
		if (ifu_rvalid !== 1'b0)
			fail_run({"ifu_rvalid is not low ", when});
		if (lsu_rvalid !== 1'b0)
			fail_run({"lsu_rvalid is not low ", when});
		if (lsu_bvalid !== 1'b0)
			fail_run({"lsu_bvalid is not low ", when});
		if (ifu_arready !== 1'b0)
			fail_run({"ifu_arready is not low ", when});
		if (lsu_arready !== 1'b0)
			fail_run({"lsu_arready is not low ", when});
	endtask

	function automatic string port_name(input port_e port);
		return port == PORT_IFU ? "ifu" : "lsu";
	endfunction

	task automatic set_ar(input port_e port, input logic valid, input axi_pkg::addr_t addr);
		if (port == PORT_IFU) begin
			ifu_ar.addr = addr;
			ifu_arvalid = valid;
		end else begin
			lsu_ar.addr = addr;
			lsu_arvalid = valid;
		end
	endtask

	task automatic set_rready(input port_e port, input logic ready);
		if (port == PORT_IFU)
			ifu_rready = ready;
		else
			lsu_rready = ready;
	endtask

	function automatic logic arready_of(input port_e port);
		return port == PORT_IFU ? ifu_arready : lsu_arready;
	endfunction

	function automatic logic rvalid_of(input port_e port);
		return port == PORT_IFU ? ifu_rvalid : lsu_rvalid;
	endfunction

	function automatic axi_pkg::r_t r_of(input port_e port);
		return port == PORT_IFU ? ifu_r : lsu_r;
	endfunction

	function automatic logic in_window(input axi_pkg::addr_t addr);
		return addr >= SRAM_BASE_TB && addr < SRAM_END_TB;
	endfunction

	function automatic int word_idx(input axi_pkg::addr_t addr);
		return int'((addr - SRAM_BASE_TB) >> 2);
	endfunction

	// Unmapped reads answer with zero data.
	function automatic axi_pkg::r_t expected_r(input axi_pkg::addr_t addr,
			input axi_pkg::resp_t resp);
		axi_pkg::r_t exp;
		exp.data = in_window(addr) ? shadow[word_idx(addr)] : '0;
		exp.resp = resp;
		return exp;
	endfunction

	task automatic update_shadow(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
			input axi_pkg::strb_t strb);
		int idx;
		idx = word_idx(addr);
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				shadow[idx][8*i +: 8] = data[8*i +: 8];
		end
	endtask

	// Starts and ends 2 ns after a rising edge. Handshakes are sampled at the falling edge.
	task automatic read_port(input port_e port, input axi_pkg::addr_t addr, input int stall,
			output axi_pkg::r_t rsp, output int valid_cyc, output int hs_cyc);
		int n;
		axi_pkg::r_t held;
		set_ar(port, 1'b1, addr);
		n = 0;
		@(negedge clk);
		while (!arready_of(port)) begin
			n++;
			if (n == TIMEOUT)
				fail_run({port_name(port), "_arready never came within the timeout"});
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		set_ar(port, 1'b0, addr);
		n = 0;
		@(negedge clk);
		while (!rvalid_of(port)) begin
			n++;
			if (n == TIMEOUT)
				fail_run({port_name(port), "_rvalid never came within the timeout"});
			@(negedge clk);
		end
		valid_cyc = cycle_cnt;
		held = r_of(port);
		repeat (stall) begin
			@(posedge clk);
			#2;
			@(negedge clk);
			if (!rvalid_of(port))
				fail_run({port_name(port), "_rvalid dropped before its handshake"});
			check_r({port_name(port), "_r"}, held, r_of(port));
		end
		@(posedge clk);
		#2;
		set_rready(port, 1'b1);
		@(negedge clk);
		if (!rvalid_of(port))
			fail_run({port_name(port), "_rvalid dropped before its handshake"});
		check_r({port_name(port), "_r"}, held, r_of(port));
		hs_cyc = cycle_cnt;
		@(posedge clk);
		#2;
		set_rready(port, 1'b0);
		rsp = held;
	endtask

	task automatic write_lsu(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
			input axi_pkg::strb_t strb, input int stall, output axi_pkg::b_t rsp);
		int n;
		logic aw_hs, w_hs;
		axi_pkg::b_t held;
		lsu_aw.addr = addr;
		lsu_w.data  = data;
		lsu_w.strb  = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		n = 0;
		// AW and W may complete in different cycles.
		while (lsu_awvalid || lsu_wvalid) begin
			if (n == TIMEOUT && lsu_awvalid)
				fail_run("lsu_awready never came within the timeout");
			if (n == TIMEOUT)
				fail_run("lsu_wready never came within the timeout");
			@(negedge clk);
			aw_hs = lsu_awvalid && lsu_awready;
			w_hs  = lsu_wvalid && lsu_wready;
			@(posedge clk);
			#2;
			if (aw_hs)
				lsu_awvalid = 1'b0;
			if (w_hs)
				lsu_wvalid = 1'b0;
			n++;
		end
		n = 0;
		@(negedge clk);
		while (!lsu_bvalid) begin
			n++;
			if (n == TIMEOUT)
				fail_run("lsu_bvalid never came within the timeout");
			@(negedge clk);
		end
		held = lsu_b;
		repeat (stall) begin
			@(posedge clk);
			#2;
			@(negedge clk);
			if (!lsu_bvalid)
				fail_run("lsu_bvalid dropped before its handshake");
			check_b("lsu_b", held, lsu_b);
		end
		@(posedge clk);
		#2;
		lsu_bready = 1'b1;
		@(negedge clk);
		if (!lsu_bvalid)
			fail_run("lsu_bvalid dropped before its handshake");
		check_b("lsu_b", held, lsu_b);
		@(posedge clk);
		#2;
		lsu_bready = 1'b0;
		rsp = held;
	endtask

	task automatic apply_read(input row_t row);
		axi_pkg::r_t exp, act;
		int valid_cyc, hs_cyc;
		exp = expected_r(row.addr, row.resp);
		read_port(row.port, row.addr, $urandom % 4, act, valid_cyc, hs_cyc);
		check_r({port_name(row.port), "_r"}, exp, act);
	endtask

	task automatic apply_write(input row_t row);
		axi_pkg::b_t exp, act;
		exp.resp = row.resp;
		write_lsu(row.addr, row.wdata, row.strb, $urandom % 4, act);
		check_b("lsu_b", exp, act);
		if (in_window(row.addr))
			update_shadow(row.addr, row.wdata, row.strb);
	endtask

	task automatic apply_dual_read(input row_t row);
		axi_pkg::r_t exp_i, exp_l, act_i, act_l;
		int valid_i, hs_i, valid_l, hs_l;
		exp_i = expected_r(row.addr, row.resp);
		exp_l = expected_r(row.addr2, row.resp2);
		// The ifu always stalls so the lsu must wait through back-pressure.
		fork
			read_port(PORT_IFU, row.addr, 3, act_i, valid_i, hs_i);
			read_port(PORT_LSU, row.addr2, $urandom % 4, act_l, valid_l, hs_l);
		join
		check_r("ifu_r", exp_i, act_i);
		check_r("lsu_r", exp_l, act_l);
		if (valid_l <= valid_i)
			fail_run("lsu_rvalid rose before ifu_rvalid on a same-cycle read");
		if (valid_l <= hs_i)
			fail_run("lsu read was answered before the ifu R handshake");
	endtask

	task automatic apply_write_during_read(input row_t row);
		axi_pkg::r_t exp_r, act_r;
		axi_pkg::b_t exp_b, act_b;
		int valid_cyc, hs_cyc;
		exp_r = expected_r(row.addr2, row.resp2);
		exp_b.resp = row.resp;
		fork
			read_port(PORT_IFU, row.addr2, $urandom % 4, act_r, valid_cyc, hs_cyc);
			begin
				repeat (2) begin
					@(posedge clk);
					#2;
				end
				write_lsu(row.addr, row.wdata, row.strb, $urandom % 4, act_b);
			end
		join
		check_r("ifu_r", exp_r, act_r);
		check_b("lsu_b", exp_b, act_b);
		if (in_window(row.addr))
			update_shadow(row.addr, row.wdata, row.strb);
	endtask

	initial begin
		void'($urandom(32'hbec2943f));
		rst_n       = 1'b0;
		ifu_ar      = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_ar      = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_aw      = '0;
		lsu_awvalid = 1'b0;
		lsu_w       = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;

		repeat (2) @(posedge clk);
		@(negedge clk);
		check_idle("while reset is asserted");
		@(posedge clk);
		#2;
		rst_n = 1'b1; // Released after three rising edges.
		@(negedge clk);
		check_idle("just after reset release");
		@(posedge clk);
		#2;

		for (int i = 0; i < NUM_ROWS; i++) begin
			case (rows[i].kind)
				RD:           apply_read(rows[i]);
				WR:           apply_write(rows[i]);
				DUAL_RD:      apply_dual_read(rows[i]);
				WR_DURING_RD: apply_write_during_read(rows[i]);
			endcase
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/addr_router.sv
`default_nettype none
`timescale 1ns/100ps

`include "bus_macros.svh"

module addr_router (
	input  wire            clk,
	input  wire            rst_n,

	input  axi_pkg::ar_t   ar,
	input  wire            arvalid,
	output logic           arready,
	output axi_pkg::r_t    r,
	output logic           rvalid,
	input  wire            rready,
	input  axi_pkg::aw_t   aw,
	input  wire            awvalid,
	output logic           awready,
	input  axi_pkg::w_t    w,
	input  wire            wvalid,
	output logic           wready,
	output axi_pkg::b_t    b,
	output logic           bvalid,
	input  wire            bready,

	output axi_pkg::ar_t   mem_ar,
	output logic           mem_arvalid,
	input  wire            mem_arready,
	input  axi_pkg::r_t    mem_r,
	input  wire            mem_rvalid,
	output logic           mem_rready,
	output axi_pkg::aw_t   mem_aw,
	output logic           mem_awvalid,
	input  wire            mem_awready,
	output axi_pkg::w_t    mem_w,
	output logic           mem_wvalid,
	input  wire            mem_wready,
	input  axi_pkg::b_t    mem_b,
	input  wire            mem_bvalid,
	output logic           mem_bready
);

	localparam axi_pkg::addr_t SRAM_END = `SRAM_BASE + `SRAM_WORDS * 4;

	logic ar_hit, aw_hit;
	logic rd_err_q, wr_err_q;
	logic wr_block;

	assign ar_hit = ar.addr >= `SRAM_BASE && ar.addr < SRAM_END;
	assign aw_hit = aw.addr >= `SRAM_BASE && aw.addr < SRAM_END;

	// Misses are taken right away and answered from here.
	assign mem_ar      = ar;
	assign mem_arvalid = arvalid && ar_hit && !rd_err_q;
	assign arready     = !rd_err_q && (ar_hit ? mem_arready : 1'b1);

	assign r          = rd_err_q ? '{data: '0, resp: axi_pkg::RESP_DECERR} : mem_r;
	assign rvalid     = rd_err_q || mem_rvalid;
	assign mem_rready = rready && !rd_err_q;

	// A pending B of either source holds off the next write, keeping responses in order.
	assign wr_block = wr_err_q || mem_bvalid;

	assign mem_aw      = aw;
	assign mem_w       = w;
	assign mem_awvalid = awvalid && aw_hit && !wr_block;
	assign mem_wvalid  = wvalid && awvalid && aw_hit && !wr_block; // W follows the AW address.
	assign awready     = !wr_block && (aw_hit ? mem_awready : wvalid);
	assign wready      = !wr_block && awvalid && (aw_hit ? mem_wready : 1'b1);

	assign b          = wr_err_q ? '{resp: axi_pkg::RESP_DECERR} : mem_b;
	assign bvalid     = wr_err_q || mem_bvalid;
	assign mem_bready = bready && !wr_err_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_err_q <= 1'b0;
			wr_err_q <= 1'b0;
		end else begin
			if (rd_err_q)
				rd_err_q <= !rready;
			else
				rd_err_q <= arvalid && !ar_hit;
			if (wr_err_q)
				wr_err_q <= !bready;
			else
				wr_err_q <= awvalid && wvalid && !aw_hit && !mem_bvalid;
		end
	end

endmodule

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

`include "bus_macros.svh"

package axi_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`DATA_W/8-1:0] strb_t;

	// Standard AXI response encodings.
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	// Read address channel.
	typedef struct packed {
		addr_t addr;
	} ar_t;

	// Read data channel.
	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_t;

	// Write address channel.
	typedef struct packed {
		addr_t addr;
	} aw_t;

	// Write data channel with one strobe bit per byte lane.
	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	// Write response channel.
	typedef struct packed {
		resp_t resp;
	} b_t;

endpackage

`default_nettype wire

// File: verilog/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// Address and data widths of every AXI-lite channel in the subsystem.
`define ADDR_W 32
`define DATA_W 32

// The SRAM window spans SRAM_WORDS*4 bytes from SRAM_BASE.
// Any other address is unmapped and gets a decode error.
`define SRAM_BASE 32'h8000_0000
`define SRAM_WORDS 1024

// Cycles from the AR handshake at the SRAM to its rvalid.
// Must be at least one.
`define SRAM_RD_LATENCY 2

`endif

// File: verilog/channel_slice.sv
`default_nettype none
`timescale 1ns/100ps

module channel_slice #(
	parameter type payload_t = logic
) (
	input  wire      clk,
	input  wire      rst_n,

	input  payload_t in_data,
	input  wire      in_valid,
	output logic     in_ready,

	output payload_t out_data,
	output logic     out_valid,
	input  wire      out_ready
);

	logic     full_q;
	payload_t data_q;

	// Room when empty or when the held item leaves this cycle.
	assign in_ready  = !full_q || out_ready;
	assign out_valid = full_q;
	assign out_data  = data_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full_q <= 1'b0;
		end else if (in_ready) begin
			full_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	// Master that currently owns the shared read path.
	typedef enum logic [1:0] {
		NONE = 2'd0,
		IFU  = 2'd1,
		LSU  = 2'd2
	} requester_e;

	// Arbiter state. busy is set once the owner's AR has been
	// handed downstream and stays set until its R handshake.
	typedef struct packed {
		requester_e owner;
		logic       busy;
	} grant_state_t;

endpackage

`default_nettype wire

// File: verilog/mem_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module mem_arbiter (
	input  wire            clk,
	input  wire            rst_n,

	input  axi_pkg::ar_t   ifu_ar,
	input  wire            ifu_arvalid,
	output logic           ifu_arready,
	output axi_pkg::r_t    ifu_r,
	output logic           ifu_rvalid,
	input  wire            ifu_rready,

	input  axi_pkg::ar_t   lsu_ar,
	input  wire            lsu_arvalid,
	output logic           lsu_arready,
	output axi_pkg::r_t    lsu_r,
	output logic           lsu_rvalid,
	input  wire            lsu_rready,

	input  axi_pkg::aw_t   lsu_aw,
	input  wire            lsu_awvalid,
	output logic           lsu_awready,
	input  axi_pkg::w_t    lsu_w,
	input  wire            lsu_wvalid,
	output logic           lsu_wready,
	output axi_pkg::b_t    lsu_b,
	output logic           lsu_bvalid,
	input  wire            lsu_bready,

	output axi_pkg::ar_t   ar,
	output logic           arvalid,
	input  wire            arready,
	input  axi_pkg::r_t    r,
	input  wire            rvalid,
	output logic           rready,

	output axi_pkg::aw_t   aw,
	output logic           awvalid,
	input  wire            awready,
	output axi_pkg::w_t    w,
	output logic           wvalid,
	input  wire            wready,
	input  axi_pkg::b_t    b,
	input  wire            bvalid,
	output logic           bready
);

	core_pkg::grant_state_t grant_q, grant_d;
	logic ifu_own, lsu_own;

	assign ifu_own = grant_q.owner == core_pkg::IFU;
	assign lsu_own = grant_q.owner == core_pkg::LSU;

	always_comb begin
		grant_d = grant_q;
		if (grant_q.owner == core_pkg::NONE) begin
			if (ifu_arvalid) begin
				grant_d.owner = core_pkg::IFU; // ifu wins a tie.
			end else if (lsu_arvalid) begin
				grant_d.owner = core_pkg::LSU;
			end
		end else begin
			if (arvalid && arready)
				grant_d.busy = 1'b1;
			// The owner's R handshake ends the read and frees the path.
			if (rvalid && rready)
				grant_d = '{owner: core_pkg::NONE, busy: 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			grant_q <= '{owner: core_pkg::NONE, busy: 1'b0};
		else
			grant_q <= grant_d;
	end

	// Only one read in flight, so no second AR once busy is set.
	assign ar      = ifu_own ? ifu_ar : lsu_ar;
	assign arvalid = !grant_q.busy && (ifu_own && ifu_arvalid || lsu_own && lsu_arvalid);
	assign ifu_arready = ifu_own && !grant_q.busy && arready;
	assign lsu_arready = lsu_own && !grant_q.busy && arready;

	assign ifu_r      = ifu_own ? r : '0;
	assign lsu_r      = lsu_own ? r : '0;
	assign ifu_rvalid = ifu_own && rvalid;
	assign lsu_rvalid = lsu_own && rvalid;
	assign rready     = ifu_own && ifu_rready || lsu_own && lsu_rready;

	// Writes come only from the lsu and bypass arbitration.
	assign aw          = lsu_aw;
	assign awvalid     = lsu_awvalid;
	assign lsu_awready = awready;
	assign w           = lsu_w;
	assign wvalid      = lsu_wvalid;
	assign lsu_wready  = wready;
	assign lsu_b       = b;
	assign lsu_bvalid  = bvalid;
	assign bready      = lsu_bready;

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_top (
	input  wire            clk,
	input  wire            rst_n,

	input  axi_pkg::ar_t   ifu_ar,
	input  wire            ifu_arvalid,
	output logic           ifu_arready,
	output axi_pkg::r_t    ifu_r,
	output logic           ifu_rvalid,
	input  wire            ifu_rready,

	input  axi_pkg::ar_t   lsu_ar,
	input  wire            lsu_arvalid,
	output logic           lsu_arready,
	output axi_pkg::r_t    lsu_r,
	output logic           lsu_rvalid,
	input  wire            lsu_rready,

	input  axi_pkg::aw_t   lsu_aw,
	input  wire            lsu_awvalid,
	output logic           lsu_awready,
	input  axi_pkg::w_t    lsu_w,
	input  wire            lsu_wvalid,
	output logic           lsu_wready,
	output axi_pkg::b_t    lsu_b,
	output logic           lsu_bvalid,
	input  wire            lsu_bready
);

	// Arbiter side of the slices.
	axi_pkg::ar_t arb_ar;
	axi_pkg::aw_t arb_aw;
	logic         arb_arvalid, arb_arready, arb_awvalid, arb_awready;

	// Router side of the slices, plus the unsliced r, w and b channels.
	axi_pkg::ar_t rt_ar;
	axi_pkg::aw_t rt_aw;
	logic         rt_arvalid, rt_arready, rt_awvalid, rt_awready;
	axi_pkg::r_t  rt_r;
	axi_pkg::w_t  rt_w;
	axi_pkg::b_t  rt_b;
	logic         rt_rvalid, rt_rready, rt_wvalid, rt_wready, rt_bvalid, rt_bready;

	// Router to SRAM.
	axi_pkg::ar_t mem_ar;
	axi_pkg::r_t  mem_r;
	axi_pkg::aw_t mem_aw;
	axi_pkg::w_t  mem_w;
	axi_pkg::b_t  mem_b;
	logic         mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic         mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;

	mem_arbiter mem_arbiter_i (
		.clk, .rst_n,
		.ifu_ar, .ifu_arvalid, .ifu_arready, .ifu_r, .ifu_rvalid, .ifu_rready,
		.lsu_ar, .lsu_arvalid, .lsu_arready, .lsu_r, .lsu_rvalid, .lsu_rready,
		.lsu_aw, .lsu_awvalid, .lsu_awready, .lsu_w, .lsu_wvalid, .lsu_wready,
		.lsu_b, .lsu_bvalid, .lsu_bready,
		.ar(arb_ar), .arvalid(arb_arvalid), .arready(arb_arready),
		.r(rt_r), .rvalid(rt_rvalid), .rready(rt_rready),
		.aw(arb_aw), .awvalid(arb_awvalid), .awready(arb_awready),
		.w(rt_w), .wvalid(rt_wvalid), .wready(rt_wready),
		.b(rt_b), .bvalid(rt_bvalid), .bready(rt_bready)
	);

	channel_slice #(.payload_t(axi_pkg::ar_t)) ar_slice (
		.clk, .rst_n,
		.in_data(arb_ar), .in_valid(arb_arvalid), .in_ready(arb_arready),
		.out_data(rt_ar), .out_valid(rt_arvalid), .out_ready(rt_arready)
	);

	channel_slice #(.payload_t(axi_pkg::aw_t)) aw_slice (
		.clk, .rst_n,
		.in_data(arb_aw), .in_valid(arb_awvalid), .in_ready(arb_awready),
		.out_data(rt_aw), .out_valid(rt_awvalid), .out_ready(rt_awready)
	);

	addr_router addr_router_i (
		.clk, .rst_n,
		.ar(rt_ar), .arvalid(rt_arvalid), .arready(rt_arready),
		.r(rt_r), .rvalid(rt_rvalid), .rready(rt_rready),
		.aw(rt_aw), .awvalid(rt_awvalid), .awready(rt_awready),
		.w(rt_w), .wvalid(rt_wvalid), .wready(rt_wready),
		.b(rt_b), .bvalid(rt_bvalid), .bready(rt_bready),
		.mem_ar, .mem_arvalid, .mem_arready, .mem_r, .mem_rvalid, .mem_rready,
		.mem_aw, .mem_awvalid, .mem_awready, .mem_w, .mem_wvalid, .mem_wready,
		.mem_b, .mem_bvalid, .mem_bready
	);

	sram_slave sram_slave_i (
		.clk, .rst_n,
		.ar(mem_ar), .arvalid(mem_arvalid), .arready(mem_arready),
		.r(mem_r), .rvalid(mem_rvalid), .rready(mem_rready),
		.aw(mem_aw), .awvalid(mem_awvalid), .awready(mem_awready),
		.w(mem_w), .wvalid(mem_wvalid), .wready(mem_wready),
		.b(mem_b), .bvalid(mem_bvalid), .bready(mem_bready)
	);

endmodule

`default_nettype wire

// File: verilog/sram_slave.sv
`default_nettype none
`timescale 1ns/100ps

`include "bus_macros.svh"

module sram_slave (
	input  wire            clk,
	input  wire            rst_n,

	input  axi_pkg::ar_t   ar,
	input  wire            arvalid,
	output logic           arready,
	output axi_pkg::r_t    r,
	output logic           rvalid,
	input  wire            rready,

	input  axi_pkg::aw_t   aw,
	input  wire            awvalid,
	output logic           awready,
	input  axi_pkg::w_t    w,
	input  wire            wvalid,
	output logic           wready,
	output axi_pkg::b_t    b,
	output logic           bvalid,
	input  wire            bready
);

	localparam int IDX_W = $clog2(`SRAM_WORDS);
	localparam int CNT_W = $clog2(`SRAM_RD_LATENCY + 1);

	logic [`DATA_W-1:0] mem [`SRAM_WORDS];

	logic               rd_busy_q;
	logic [CNT_W-1:0]   rd_cnt_q;
	logic [IDX_W-1:0]   rd_idx_q;
	logic [`DATA_W-1:0] rdata_q;
	logic [IDX_W-1:0]   wr_idx;
	logic               wr_fire;

	// A read is taken only when none is pending and is counted down from the AR handshake.
	assign arready = !rd_busy_q && !rvalid;
	assign r       = '{data: rdata_q, resp: axi_pkg::RESP_OKAY};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy_q <= 1'b0;
			rd_cnt_q  <= '0;
			rvalid    <= 1'b0;
		end else if (arvalid && arready) begin
			rd_busy_q <= 1'b1;
			rd_cnt_q  <= CNT_W'(`SRAM_RD_LATENCY - 1);
		end else if (rd_busy_q) begin
			if (rd_cnt_q == '0) begin
				rd_busy_q <= 1'b0;
				rvalid    <= 1'b1;
			end else begin
				rd_cnt_q <= rd_cnt_q - 1'b1;
			end
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rd_idx_q <= ar.addr[IDX_W+1:2]; // Word offset inside the window.
		if (rd_busy_q && rd_cnt_q == '0)
			rdata_q <= mem[rd_idx_q];
	end

	// AW and W are taken together and only when no B is waiting.
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign wr_idx  = aw.addr[IDX_W+1:2];
	assign b       = '{resp: axi_pkg::RESP_OKAY};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `DATA_W / 8; i++) begin
			if (wr_fire && w.strb[i])
				mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
		end
	end

endmodule

`default_nettype wire
